/* source/pixel_filter_config.svh */
`ifndef PIXEL_FILTER_CONFIG_SVH
`define PIXEL_FILTER_CONFIG_SVH

////////////////////////////////////////
// stream widths
////////////////////////////////////////

// one colour channel of the incoming 24-bit pixel
`define PF_CHAN_W 8

// one channel of the RGB444 output
`define PF_OUT_W 4

// filter select code
`define PF_SEL_W 4

// step used by brighten, darken and the channel cuts
`define PF_BRIGHT_STEP 8

`endif

/* source/pixel_filter_pkg.sv */
`include "pixel_filter_config.svh"

package pixel_filter_pkg;

   ////////////////////////////////////////
   // channel types
   ////////////////////////////////////////

   // one input colour channel
   typedef logic [`PF_CHAN_W-1:0] chan_t;

   // one output channel after reduction
   typedef logic [`PF_OUT_W-1:0] out_chan_t;

   ////////////////////////////////////////
   // filter opcodes
   ////////////////////////////////////////

   // codes 8 to 15 carry no name and act as passthrough
   typedef enum logic [`PF_SEL_W-1:0] {
      // luma approximation on all three channels
      OP_GRAY      = 0,
      // add step with clamp at full scale
      OP_BRIGHTEN  = 1,
      // subtract step with floor at zero
      OP_DARKEN    = 2,
      // full scale minus channel
      OP_INVERT    = 3,
      // darken red only
      OP_CUT_RED   = 4,
      // darken blue only
      OP_CUT_BLUE  = 5,
      // darken green only
      OP_CUT_GREEN = 6,
      // copy pixel unchanged
      OP_PASS      = 7
   } filter_op_e;

endpackage

/* source/pixel_capture.sv */
`timescale 1ns/1ps

`include "pixel_filter_config.svh"

module pixel_capture (
   input  logic                         clock,
   input  logic                         reset,
   input  logic [`PF_SEL_W-1:0]         sel_i,
   input  logic                         active_i,
   input  pixel_filter_pkg::chan_t      red_i,
   input  pixel_filter_pkg::chan_t      green_i,
   input  pixel_filter_pkg::chan_t      blue_i,
   output pixel_filter_pkg::chan_t      red_o,
   output pixel_filter_pkg::chan_t      green_o,
   output pixel_filter_pkg::chan_t      blue_o,
   output pixel_filter_pkg::filter_op_e op_o,
   output logic                         active_o
);
   import pixel_filter_pkg::*;

   logic strobe;

   ////////////////////////////////////////
   // pixel strobe at half clock rate
   ////////////////////////////////////////

   // held high in reset so the first edge after release captures
   always_ff @(posedge clock) begin
      if (reset) begin
         strobe <= 1'b1;
      end else begin
         strobe <= ~strobe;
      end
   end

   ////////////////////////////////////////
   // capture registers
   ////////////////////////////////////////

   // control state
   always_ff @(posedge clock) begin
      if (reset) begin
         op_o     <= OP_PASS;
         active_o <= 1'b0;
      end else if (strobe) begin
         op_o     <= filter_op_e'(sel_i);
         active_o <= active_i;
      end
   end

   // pixel payload
   always_ff @(posedge clock) begin
      if (strobe) begin
         red_o   <= red_i;
         green_o <= green_i;
         blue_o  <= blue_i;
      end
   end

   // strobe must alternate once running
   a_strobe_alternates : assert property (
      @(posedge clock) disable iff (reset)
      (!reset && strobe) |=> !strobe
   );

endmodule

/* source/point_op_unit.sv */
`timescale 1ns/1ps

`include "pixel_filter_config.svh"

module point_op_unit (
   input  logic                         clock,
   input  logic                         reset,
   input  pixel_filter_pkg::chan_t      red_i,
   input  pixel_filter_pkg::chan_t      green_i,
   input  pixel_filter_pkg::chan_t      blue_i,
   input  pixel_filter_pkg::filter_op_e op_i,
   input  logic                         active_i,
   output pixel_filter_pkg::chan_t      red_o,
   output pixel_filter_pkg::chan_t      green_o,
   output pixel_filter_pkg::chan_t      blue_o,
   output logic                         active_o
);
   import pixel_filter_pkg::*;

   chan_t luma;
   chan_t red_n;
   chan_t green_n;
   chan_t blue_n;

   ////////////////////////////////////////
   // saturating helpers
   ////////////////////////////////////////

   // add step and clamp at full scale
   function automatic chan_t sat_add(input chan_t c);
      logic [`PF_CHAN_W:0] sum;
      sum = {1'b0, c} + (`PF_CHAN_W+1)'(`PF_BRIGHT_STEP);
      if (sum[`PF_CHAN_W]) begin
         return '1;
      end
      return sum[`PF_CHAN_W-1:0];
   endfunction

   // subtract step with floor at zero
   function automatic chan_t sat_sub(input chan_t c);
      chan_t step;
      step = chan_t'(`PF_BRIGHT_STEP);
      if (c < step) begin
         return '0;
      end
      return c - step;
   endfunction

   ////////////////////////////////////////
   // luma approximation
   ////////////////////////////////////////

   // roughly 0.28 r + 0.56 g + 0.09 b, never exceeds 234
   always_comb begin
      luma = (red_i >> 2) + (red_i >> 5)
           + (green_i >> 1) + (green_i >> 4)
           + (blue_i >> 4) + (blue_i >> 5);
   end

   ////////////////////////////////////////
   // operation select
   ////////////////////////////////////////

   always_comb begin
      // passthrough unless an opcode says otherwise
      red_n   = red_i;
      green_n = green_i;
      blue_n  = blue_i;
      case (op_i)
         OP_GRAY: begin
            red_n   = luma;
            green_n = luma;
            blue_n  = luma;
         end
         OP_BRIGHTEN: begin
            red_n   = sat_add(red_i);
            green_n = sat_add(green_i);
            blue_n  = sat_add(blue_i);
         end
         OP_DARKEN: begin
            red_n   = sat_sub(red_i);
            green_n = sat_sub(green_i);
            blue_n  = sat_sub(blue_i);
         end
         OP_INVERT: begin
            red_n   = ~red_i;
            green_n = ~green_i;
            blue_n  = ~blue_i;
         end
         OP_CUT_RED: begin
            red_n = sat_sub(red_i);
         end
         OP_CUT_BLUE: begin
            blue_n = sat_sub(blue_i);
         end
         OP_CUT_GREEN: begin
            green_n = sat_sub(green_i);
         end
         default: begin
            // OP_PASS and the unnamed codes 8 to 15
            red_n   = red_i;
            green_n = green_i;
            blue_n  = blue_i;
         end
      endcase
   end

   ////////////////////////////////////////
   // result registers
   ////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         active_o <= 1'b0;
      end else begin
         active_o <= active_i;
      end
   end

   always_ff @(posedge clock) begin
      red_o   <= red_n;
      green_o <= green_n;
      blue_o  <= blue_n;
   end

   // brighten never lowers a channel, clamp included
   a_brighten_monotonic : assert property (
      @(posedge clock) disable iff (reset)
      (active_i && op_i == OP_BRIGHTEN) |=>
         (red_o >= $past(red_i)) &&
         (green_o >= $past(green_i)) &&
         (blue_o >= $past(blue_i))
   );

endmodule

/* source/rgb444_output.sv */
`timescale 1ns/1ps

`include "pixel_filter_config.svh"

module rgb444_output (
   input  logic                        clock,
   input  logic                        reset,
   input  pixel_filter_pkg::chan_t     red_i,
   input  pixel_filter_pkg::chan_t     green_i,
   input  pixel_filter_pkg::chan_t     blue_i,
   input  logic                        active_i,
   output pixel_filter_pkg::out_chan_t red_o,
   output pixel_filter_pkg::out_chan_t green_o,
   output pixel_filter_pkg::out_chan_t blue_o
);
   import pixel_filter_pkg::*;

   out_chan_t red_n;
   out_chan_t green_n;
   out_chan_t blue_n;

   ////////////////////////////////////////
   // channel reduction
   ////////////////////////////////////////

   // keep the upper nibble of each channel
   always_comb begin
      red_n   = red_i[`PF_CHAN_W-1 -: `PF_OUT_W];
      green_n = green_i[`PF_CHAN_W-1 -: `PF_OUT_W];
      blue_n  = blue_i[`PF_CHAN_W-1 -: `PF_OUT_W];
   end

   ////////////////////////////////////////
   // output register with blanking
   ////////////////////////////////////////

   // black during blanking and under reset
   always_ff @(posedge clock) begin
      if (reset || !active_i) begin
         red_o   <= '0;
         green_o <= '0;
         blue_o  <= '0;
      end else begin
         red_o   <= red_n;
         green_o <= green_n;
         blue_o  <= blue_n;
      end
   end

   // blanked pixel shows black on the next cycle
   a_blank_is_black : assert property (
      @(posedge clock)
      !active_i |=> (red_o == '0) && (green_o == '0) && (blue_o == '0)
   );

endmodule

/* source/pixel_filter_top.sv */
`timescale 1ns/1ps

`include "pixel_filter_config.svh"

module pixel_filter_top (
   input  logic                        clock,
   input  logic                        reset,
   input  logic [`PF_SEL_W-1:0]        sel_i,
   input  logic                        active_i,
   input  pixel_filter_pkg::chan_t     red_i,
   input  pixel_filter_pkg::chan_t     green_i,
   input  pixel_filter_pkg::chan_t     blue_i,
   output pixel_filter_pkg::out_chan_t red_o,
   output pixel_filter_pkg::out_chan_t green_o,
   output pixel_filter_pkg::out_chan_t blue_o
);

   // capture to point operation
   pixel_filter_pkg::chan_t      cap_red;
   pixel_filter_pkg::chan_t      cap_green;
   pixel_filter_pkg::chan_t      cap_blue;
   pixel_filter_pkg::filter_op_e cap_op;
   logic                         cap_active;

   // point operation to output
   pixel_filter_pkg::chan_t      res_red;
   pixel_filter_pkg::chan_t      res_green;
   pixel_filter_pkg::chan_t      res_blue;
   logic                         res_active;

   pixel_capture u_capture (
      .clock    (clock),
      .reset    (reset),
      .sel_i    (sel_i),
      .active_i (active_i),
      .red_i    (red_i),
      .green_i  (green_i),
      .blue_i   (blue_i),
      .red_o    (cap_red),
      .green_o  (cap_green),
      .blue_o   (cap_blue),
      .op_o     (cap_op),
      .active_o (cap_active)
   );

   point_op_unit u_point_op (
      .clock    (clock),
      .reset    (reset),
      .red_i    (cap_red),
      .green_i  (cap_green),
      .blue_i   (cap_blue),
      .op_i     (cap_op),
      .active_i (cap_active),
      .red_o    (res_red),
      .green_o  (res_green),
      .blue_o   (res_blue),
      .active_o (res_active)
   );

   rgb444_output u_output (
      .clock    (clock),
      .reset    (reset),
      .red_i    (res_red),
      .green_i  (res_green),
      .blue_i   (res_blue),
      .active_i (res_active),
      .red_o    (red_o),
      .green_o  (green_o),
      .blue_o   (blue_o)
   );

endmodule

/* verification/pixel_filter_tb.sv */
`timescale 1ns/1ps

`include "pixel_filter_config.svh"

module pixel_filter_tb;

   localparam int CLK_PERIOD = 10;
   // brighten and darken step of the filter
   localparam int STEP = 8;

   // select codes of the filter
   localparam logic [3:0] SEL_GRAY      = 4'd0;
   localparam logic [3:0] SEL_BRIGHTEN  = 4'd1;
   localparam logic [3:0] SEL_DARKEN    = 4'd2;
   localparam logic [3:0] SEL_INVERT    = 4'd3;
   localparam logic [3:0] SEL_CUT_RED   = 4'd4;
   localparam logic [3:0] SEL_CUT_BLUE  = 4'd5;
   localparam logic [3:0] SEL_CUT_GREEN = 4'd6;

   // two-cycle pixel slots per test, one flush slot each
   localparam int SLOTS_RESET    = 2 + 16 + 1;
   localparam int SLOTS_PASS     = 36 + 1;
   localparam int SLOTS_GRAY_INV = 12 + 1;
   localparam int SLOTS_BRIGHT   = 16 + 1;
   localparam int SLOTS_CUT      = 18 + 1;
   localparam int SLOTS_PACE     = 20 + 1;
   localparam int TOTAL_SLOTS    = SLOTS_RESET + SLOTS_PASS + SLOTS_GRAY_INV
                                 + SLOTS_BRIGHT + SLOTS_CUT + SLOTS_PACE;
   localparam int TIMEOUT_NS     = TOTAL_SLOTS * 2 * CLK_PERIOD + 50 * CLK_PERIOD;

   logic                  clock;
   logic                  reset;
   logic [`PF_SEL_W-1:0]  sel;
   logic                  active;
   logic [`PF_CHAN_W-1:0] red;
   logic [`PF_CHAN_W-1:0] green;
   logic [`PF_CHAN_W-1:0] blue;
   logic [`PF_OUT_W-1:0]  red_o;
   logic [`PF_OUT_W-1:0]  green_o;
   logic [`PF_OUT_W-1:0]  blue_o;

   integer seed;
   int     errors;
   int     checks;
   int     tests;

   // expected RGB444 words still in flight
   logic [11:0] exp_q[$];
   string       what_q[$];

   pixel_filter_top dut0 (
      .clock    (clock),
      .reset    (reset),
      .sel_i    (sel),
      .active_i (active),
      .red_i    (red),
      .green_i  (green),
      .blue_i   (blue),
      .red_o    (red_o),
      .green_o  (green_o),
      .blue_o   (blue_o)
   );

   initial begin
      clock = 1'b0;
      forever #(CLK_PERIOD/2) clock = ~clock;
   end

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////

   function automatic logic [11:0] expected_rgb444(input logic [3:0] op, input logic act,
                                                   input logic [7:0] r, input logic [7:0] g,
                                                   input logic [7:0] b);
      int rr;
      int gg;
      int bb;
      int y;
      logic [7:0] ro;
      logic [7:0] go;
      logic [7:0] bo;
      rr = int'(r);
      gg = int'(g);
      bb = int'(b);
      // luma approximation, truncated to one byte
      y = ((rr >> 2) + (rr >> 5) + (gg >> 1) + (gg >> 4) + (bb >> 4) + (bb >> 5)) % 256;
      case (op)
         SEL_GRAY: begin
            rr = y;
            gg = y;
            bb = y;
         end
         SEL_BRIGHTEN: begin
            rr = (rr + STEP > 255) ? 255 : rr + STEP;
            gg = (gg + STEP > 255) ? 255 : gg + STEP;
            bb = (bb + STEP > 255) ? 255 : bb + STEP;
         end
         SEL_DARKEN: begin
            rr = (rr < STEP) ? 0 : rr - STEP;
            gg = (gg < STEP) ? 0 : gg - STEP;
            bb = (bb < STEP) ? 0 : bb - STEP;
         end
         SEL_INVERT: begin
            rr = 255 - rr;
            gg = 255 - gg;
            bb = 255 - bb;
         end
         SEL_CUT_RED: begin
            rr = (rr < STEP) ? 0 : rr - STEP;
         end
         SEL_CUT_BLUE: begin
            bb = (bb < STEP) ? 0 : bb - STEP;
         end
         SEL_CUT_GREEN: begin
            gg = (gg < STEP) ? 0 : gg - STEP;
         end
         default: begin
            // passthrough, codes 7 to 15
         end
      endcase
      ro = 8'(rr);
      go = 8'(gg);
      bo = 8'(bb);
      if (!act) begin
         return 12'h000;
      end
      return {ro[7:4], go[7:4], bo[7:4]};
   endfunction

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////

   task automatic check_value(input logic [11:0] expected, input logic [11:0] actual,
                              input string what);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAIL at %0d ns: %s expected %h got %h", $time, what, expected, actual);
      end
   endtask

   // drop removes the entry once its last output cycle is checked
   task automatic compare_oldest(input bit drop);
      check_value(exp_q[0], {red_o, green_o, blue_o}, what_q[0]);
      if (drop) begin
         void'(exp_q.pop_front());
         void'(what_q.pop_front());
      end
   endtask

   task automatic random_pixel(output logic [7:0] r, output logic [7:0] g,
                               output logic [7:0] b);
      logic [31:0] word;
      word = $random(seed);
      r = word[7:0];
      g = word[15:8];
      b = word[23:16];
   endtask

   // one pixel per strobe pair, the pixel of the previous slot is checked
   // on both of its output cycles
   task automatic send_pixel(input logic [3:0] op, input logic act, input logic [7:0] r,
                             input logic [7:0] g, input logic [7:0] b, input string tag);
      sel = op;
      active = act;
      red = r;
      green = g;
      blue = b;
      exp_q.push_back(expected_rgb444(op, act, r, g, b));
      what_q.push_back($sformatf("%s sel %0d rgb %h %h %h", tag, op, r, g, b));
      @(posedge clock);
      #1;
      if (exp_q.size() > 1) begin
         compare_oldest(1'b0);
      end
      @(posedge clock);
      #1;
      if (exp_q.size() > 1) begin
         compare_oldest(1'b1);
      end
   endtask

   task automatic flush_pipeline();
      active = 1'b0;
      @(posedge clock);
      #1;
      if (exp_q.size() > 0) begin
         compare_oldest(1'b0);
      end
      @(posedge clock);
      #1;
      while (exp_q.size() > 0) begin
         compare_oldest(1'b1);
      end
   endtask

   task automatic finish_test(input string name, input int err_before);
      tests++;
      if (errors == err_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - err_before);
      end
   endtask

   ////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////

   task automatic reset_and_blanking();
      int err_before;
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
      err_before = errors;
      // active pixels on the inputs while reset is held
      for (int i = 0; i < 4; i++) begin
         @(posedge clock);
         #1;
         check_value(12'h000, {red_o, green_o, blue_o}, "outputs under reset");
         random_pixel(r, g, b);
         sel = 4'(i * 5);
         active = 1'b1;
         red = r;
         green = g;
         blue = b;
      end
      reset = 1'b0;
      for (int s = 0; s < 16; s++) begin
         random_pixel(r, g, b);
         send_pixel(4'(s), 1'b0, r, g, b, "blank");
      end
      flush_pipeline();
      finish_test("reset_blanking", err_before);
   endtask

   task automatic passthrough_codes();
      int err_before;
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
      err_before = errors;
      for (int s = 7; s < 16; s++) begin
         for (int i = 0; i < 4; i++) begin
            random_pixel(r, g, b);
            send_pixel(4'(s), 1'b1, r, g, b, "pass");
         end
      end
      flush_pipeline();
      finish_test("passthrough", err_before);
   endtask

   task automatic gray_and_invert();
      int err_before;
      logic [3:0] op;
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
      err_before = errors;
      for (int k = 0; k < 2; k++) begin
         op = (k == 0) ? SEL_GRAY : SEL_INVERT;
         send_pixel(op, 1'b1, 8'd0, 8'd0, 8'd0, "gray_invert");
         send_pixel(op, 1'b1, 8'd255, 8'd255, 8'd255, "gray_invert");
         for (int i = 0; i < 4; i++) begin
            random_pixel(r, g, b);
            send_pixel(op, 1'b1, r, g, b, "gray_invert");
         end
      end
      flush_pipeline();
      finish_test("gray_invert", err_before);
   endtask

   task automatic brighten_darken_clamps();
      int err_before;
      logic [3:0] op;
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
      err_before = errors;
      for (int k = 0; k < 2; k++) begin
         op = (k == 0) ? SEL_BRIGHTEN : SEL_DARKEN;
         // clamp corners and nibble edges
         send_pixel(op, 1'b1, 8'd250, 8'd3, 8'd128, "bright_dark");
         send_pixel(op, 1'b1, 8'd3, 8'd250, 8'd7, "bright_dark");
         send_pixel(op, 1'b1, 8'd255, 8'd0, 8'd8, "bright_dark");
         send_pixel(op, 1'b1, 8'd0, 8'd255, 8'd249, "bright_dark");
         for (int i = 0; i < 4; i++) begin
            random_pixel(r, g, b);
            send_pixel(op, 1'b1, r, g, b, "bright_dark");
         end
      end
      flush_pipeline();
      finish_test("bright_dark", err_before);
   endtask

   task automatic channel_cuts();
      int err_before;
      logic [3:0] op;
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
      err_before = errors;
      for (int k = 0; k < 3; k++) begin
         op = SEL_CUT_RED + 4'(k);
         send_pixel(op, 1'b1, 8'd3, 8'd3, 8'd3, "cut");
         send_pixel(op, 1'b1, 8'd250, 8'd250, 8'd250, "cut");
         for (int i = 0; i < 4; i++) begin
            random_pixel(r, g, b);
            send_pixel(op, 1'b1, r, g, b, "cut");
         end
      end
      flush_pipeline();
      finish_test("cuts", err_before);
   endtask

   task automatic pixel_pacing();
      int err_before;
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
      err_before = errors;
      // new operation on every pixel, a blank one now and then
      for (int i = 0; i < 20; i++) begin
         random_pixel(r, g, b);
         send_pixel(4'((i * 5) % 16), (i % 7) != 6, r, g, b, "pacing");
      end
      flush_pipeline();
      finish_test("pacing", err_before);
   endtask

   initial begin
      seed = 43;
      errors = 0;
      checks = 0;
      tests = 0;
      reset = 1'b1;
      sel = '0;
      active = 1'b0;
      red = '0;
      green = '0;
      blue = '0;
      reset_and_blanking();
      passthrough_codes();
      gray_and_invert();
      brighten_darken_clamps();
      channel_cuts();
      pixel_pacing();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("timeout: simulation did not finish within %0d ns", TIMEOUT_NS);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

/* src.f */
+incdir+source
source/pixel_filter_pkg.sv
source/pixel_capture.sv
source/point_op_unit.sv
source/rgb444_output.sv
source/pixel_filter_top.sv
verification/pixel_filter_tb.sv

/* Makefile */
# Verilator build and run for the pixel filter testbench

VERILATOR ?= verilator
TOP       ?= pixel_filter_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(wildcard source/*.sv source/*.svh verification/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "FAIL: see errors above" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
